/* dv/rv_core_asserts.sv */
// port-level properties of rv_core, bound into every rv_core instance; post-halt properties are off in reset
`timescale 1ns/100ps

module rv_core_asserts #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input logic          i_clk,
  input logic          i_rst_n,
  input rv_pkg::xlen_t i_pc,
  input logic          i_store_valid,
  input logic          i_halt,
  input logic          i_halt_illegal
);

  reset_state: assert property (@(posedge i_clk)
    !i_rst_n |-> (!i_store_valid && !i_halt && !i_halt_illegal && (i_pc == RESET_PC)))
    else $error("core outputs are not at their reset values while reset is low");

  // no store once the core has stopped
  no_store_when_halted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_halt |-> !i_store_valid)
    else $error("store strobe seen while halted");

  halt_is_sticky: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_halt |=> (i_halt && $stable(i_pc)))
    else $error("halt dropped or pc moved after halt");

  illegal_needs_halt: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_halt_illegal |-> i_halt)
    else $error("illegal flag set without halt");

endmodule

bind rv_core rv_core_asserts #(
  .RESET_PC(RESET_PC)
) u_asserts (
  .i_clk          (i_clk),
  .i_rst_n        (i_rst_n),
  .i_pc           (o_pc),
  .i_store_valid  (o_store_valid),
  .i_halt         (o_halt),
  .i_halt_illegal (o_halt_illegal)
);

/* dv/rv_core_checker.sv */
// reference model of the subset; fetch outside the 256-word rom or off a word boundary gives ebreak
`timescale 1ns/100ps

module rv_core_checker #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  logic          i_test_end,
  input  rv_pkg::xlen_t i_pc,
  input  logic          i_store_valid,
  input  rv_pkg::xlen_t i_store_addr,
  input  rv_pkg::xlen_t i_store_data,
  input  logic          i_halt,
  input  logic          i_halt_illegal,
  input  rv_pkg::xlen_t i_halt_a0,
  output int            o_checks,
  output int            o_errors
);

  import rv_pkg::*;

  typedef struct packed {
    logic  store;
    logic  halt;
    logic  illegal;
    xlen_t addr;
    xlen_t data;
  } step_t;

  inst_t prog [256];
  xlen_t m_regs [32];
  xlen_t m_pc;
  logic  m_halted = 1'b0;
  logic  m_illegal = 1'b0;
  xlen_t m_a0;
  step_t ev;
  int    checks = 0;
  int    errors = 0;
  int    test_num = 0;
  int    test_errors = 0;
  int    test_stores = 0;

  assign o_checks = checks;
  assign o_errors = errors;

  function automatic inst_t fetch(input xlen_t pc);
    if ((pc < 64'd1024) && (pc[1:0] == 2'b00)) begin
      return prog[pc[9:2]];
    end
    return 32'h00100073;
  endfunction

  // one architectural step; updates m_regs and m_pc
  function automatic step_t step_model(input inst_t inst);
    step_t e;
    xlen_t rs1;
    xlen_t rs2;
    xlen_t imm_i;
    xlen_t imm_u;
    xlen_t link;
    xlen_t next;
    xlen_t wval;
    logic  wr;
    e     = '0;
    rs1   = m_regs[inst[19:15]];
    rs2   = m_regs[inst[24:20]];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
    link  = m_pc + 64'd4;
    next  = link;
    wval  = '0;
    wr    = 1'b1;
    casez ({inst[14:12], inst[6:0]})
      10'b???_0110111: wval = imm_u;
      10'b???_0010111: wval = m_pc + imm_u;
      10'b???_1101111: begin
        wval = link;
        next = m_pc + {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      10'b000_1100111: begin
        wval = link;
        next = (rs1 + imm_i) & ~64'd1;
      end
      10'b000_0010011: wval = rs1 + imm_i;
      10'b011_0100011: begin
        wr      = 1'b0;
        e.store = 1'b1;
        e.addr  = rs1 + {{52{inst[31]}}, inst[31:25], inst[11:7]};
        e.data  = rs2;
      end
      default: begin
        wr        = 1'b0;
        e.halt    = 1'b1;
        e.illegal = (inst != 32'h00100073);
      end
    endcase
    if (wr && (inst[11:7] != 5'd0)) begin
      m_regs[inst[11:7]] = wval;
    end
    if (!e.halt) begin
      m_pc = next;
    end
    return e;
  endfunction

  task automatic check_value(input string what, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // sampled mid-cycle, away from the clock edge
  always @(negedge i_clk) begin
    if (!i_rst_n) begin
      m_pc      = RESET_PC;
      m_halted  = 1'b0;
      m_illegal = 1'b0;
      for (int r = 0; r < 32; r++) begin
        m_regs[r] = '0;
      end
      check_value("pc in reset", i_pc, RESET_PC);
      check_value("store strobe in reset", i_store_valid, 0);
      check_value("halt in reset", i_halt, 0);
      check_value("illegal flag in reset", i_halt_illegal, 0);
    end else if (!m_halted) begin
      check_value("pc", i_pc, m_pc);
      check_value("halt while running", i_halt, 0);
      ev = step_model(fetch(m_pc));
      check_value("store strobe", i_store_valid, ev.store);
      if (ev.store) begin
        test_stores++;
        check_value("store address", i_store_addr, ev.addr);
        check_value("store data", i_store_data, ev.data);
      end
      if (ev.halt) begin
        m_halted  = 1'b1;
        m_illegal = ev.illegal;
        m_a0      = m_regs[EBREAK_A0];
      end
    end else begin
      check_value("halt", i_halt, 1);
      check_value("illegal flag", i_halt_illegal, m_illegal);
      check_value("halt a0", i_halt_a0, m_a0);
      check_value("store strobe after halt", i_store_valid, 0);
      // the model pc stays on the halting instruction
      check_value("pc after halt", i_pc, m_pc);
    end
  end

  always @(posedge i_test_end) begin
    test_num++;
    if (!m_halted) begin
      errors++;
      test_errors++;
      $display("test %0d: the reference model never reached a halt", test_num);
    end
    $display("test %0d finished: %0d stores compared, %0d mismatches, halt by %s",
             test_num, test_stores, test_errors, m_illegal ? "illegal instruction" : "ebreak");
    test_errors = 0;
    test_stores = 0;
  end

endmodule

/* dv/tb_rv_core.sv */
// program rom sits at address 0; random programs only jump forward so every run reaches a halt
`timescale 1ns/100ps

module tb_rv_core;

  import rv_pkg::*;

  localparam xlen_t      RESET_PC   = 64'd0;
  localparam inst_t      EBREAK     = 32'h00100073;
  localparam int         HALT_LIMIT = 1000;
  localparam int         RAND_RUNS  = 4;
  localparam logic [6:0] OP_LUI     = 7'b0110111;
  localparam logic [6:0] OP_AUIPC   = 7'b0010111;
  localparam logic [6:0] OP_ADDI    = 7'b0010011;
  localparam logic [6:0] OP_JALR    = 7'b1100111;

  logic        clk;
  logic        rst_n;
  logic        test_end;
  inst_t       inst;
  xlen_t       pc;
  logic        store_valid;
  xlen_t       store_addr;
  xlen_t       store_data;
  logic        halt;
  logic        halt_illegal;
  xlen_t       halt_a0;
  int          checks;
  int          errors;
  int          tests_run = 0;
  logic        timed_out = 1'b0;
  inst_t       rom [256];
  logic [31:0] lfsr = 32'h06ad5736;

  // combinational fetch, ebreak outside the rom
  assign inst = ((pc < 64'd1024) && (pc[1:0] == 2'b00)) ? rom[pc[9:2]] : EBREAK;

  rv_core #(
    .RESET_PC(RESET_PC)
  ) u_rv_core (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_inst         (inst),
    .o_pc           (pc),
    .o_store_valid  (store_valid),
    .o_store_addr   (store_addr),
    .o_store_data   (store_data),
    .o_halt         (halt),
    .o_halt_illegal (halt_illegal),
    .o_halt_a0      (halt_a0)
  );

  rv_core_checker #(
    .RESET_PC(RESET_PC)
  ) u_checker (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_test_end     (test_end),
    .i_pc           (pc),
    .i_store_valid  (store_valid),
    .i_store_addr   (store_addr),
    .i_store_data   (store_data),
    .i_halt         (halt),
    .i_halt_illegal (halt_illegal),
    .i_halt_a0      (halt_a0),
    .o_checks       (checks),
    .o_errors       (errors)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return v;
  endfunction

  function automatic inst_t imm_inst(input logic [6:0] op, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, op};
  endfunction

  function automatic inst_t upper_inst(input logic [6:0] op, input logic [4:0] rd,
                                       input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic inst_t sd_inst(input logic [4:0] rs2, input logic [4:0] rs1,
                                    input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
  endfunction

  function automatic inst_t jal_inst(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic put(input int idx, input inst_t w);
    rom[idx]               = w;
    u_checker.prog[idx]    = w;
  endtask

  task automatic load_program(input int t);
    logic [2:0]  kind;
    logic [2:0]  hop;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [20:0] off;
    logic [11:0] tgt;
    for (int i = 0; i < 256; i++) begin
      put(i, EBREAK);
    end
    case (t)
      0: begin
        put(0, upper_inst(OP_LUI, 5, 20'h12345));
        put(1, imm_inst(OP_ADDI, 5, 5, 12'h678));
        put(2, imm_inst(OP_ADDI, 0, 5, 12'h001));
        put(3, upper_inst(OP_LUI, 7, 20'hfffff));
        put(4, upper_inst(OP_AUIPC, 6, 20'h00001));
        put(5, sd_inst(5, 6, 12'h008));
        put(6, sd_inst(7, 5, 12'hff0));
        put(7, sd_inst(0, 7, 12'h000));
        put(8, imm_inst(OP_ADDI, 10, 7, 12'h7ff));
      end
      1: begin
        // jal over two words, then jalr to an odd address
        put(0, jal_inst(1, 21'd12));
        put(1, imm_inst(OP_ADDI, 10, 0, 12'h001));
        put(3, imm_inst(OP_ADDI, 2, 0, 12'd25));
        put(4, imm_inst(OP_JALR, 3, 2, 12'h000));
        put(6, sd_inst(1, 0, 12'h000));
        put(7, sd_inst(3, 0, 12'h008));
        put(8, imm_inst(OP_ADDI, 10, 3, 12'h005));
      end
      2: begin
        put(0, imm_inst(OP_ADDI, 10, 0, 12'h007));
        put(1, imm_inst(OP_ADDI, 11, 0, 12'h003));
        // add a0, a0, a1
        put(2, 32'h00b50533);
        put(3, sd_inst(10, 0, 12'h000));
      end
      default: begin
        for (int i = 0; i < 255; i++) begin
          kind  = take_bits(3);
          hop   = take_bits(3);
          rd    = take_bits(5);
          rs1   = take_bits(5);
          rs2   = take_bits(5);
          imm12 = take_bits(12);
          imm20 = take_bits(20);
          off   = (hop + 1) << 2;
          tgt   = ((i + hop + 1) << 2) + take_bits(1);
          case (kind)
            3'd0, 3'd1: put(i, imm_inst(OP_ADDI, rd, rs1, imm12));
            3'd2: put(i, upper_inst(OP_LUI, rd, imm20));
            3'd3: put(i, upper_inst(OP_AUIPC, rd, imm20));
            3'd4, 3'd5: put(i, sd_inst(rs2, rs1, imm12));
            3'd6: put(i, jal_inst(rd, off));
            default: put(i, imm_inst(OP_JALR, rd, 0, tgt));
          endcase
        end
      end
    endcase
  endtask

  task automatic wait_halt(input int t);
    int cycles;
    cycles = 0;
    while (!halt && (cycles < HALT_LIMIT)) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      timed_out = 1'b1;
      $display("test %0d: the DUT did not halt within %0d cycles", t + 1, HALT_LIMIT);
    end
  endtask

  initial begin
    rst_n    = 1'b1;
    test_end = 1'b0;
    for (int i = 0; i < 256; i++) begin
      rom[i] = EBREAK;
    end
    // clean falling reset edge before the first clock
    #1;
    rst_n = 1'b0;
    for (int t = 0; (t < 3 + RAND_RUNS) && !timed_out; t++) begin
      @(posedge clk);
      #1;
      rst_n = 1'b0;
      load_program(t);
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      wait_halt(t);
      if (!timed_out) begin
        repeat (3) @(negedge clk);
        @(posedge clk);
        #1;
        test_end = 1'b1;
        @(posedge clk);
        #1;
        test_end = 1'b0;
        tests_run++;
      end
    end
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (!timed_out && (errors == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* hdl/rv_core.sv */
// single-cycle rv64i subset core; i_inst must follow o_pc within the same cycle and stores have no back-pressure
`timescale 1ns/100ps

module rv_core #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input  logic          i_clk,
  input  logic          i_rst_n,
  input  rv_pkg::inst_t i_inst,
  output rv_pkg::xlen_t o_pc,
  output logic          o_store_valid,
  output rv_pkg::xlen_t o_store_addr,
  output rv_pkg::xlen_t o_store_data,
  output logic          o_halt,
  output logic          o_halt_illegal,
  output rv_pkg::xlen_t o_halt_a0
);

  import rv_pkg::*;

  decode_t dec;
  xlen_t   rs1;
  xlen_t   rs2;
  xlen_t   a0;
  xlen_t   result;
  xlen_t   target;
  logic    run;

  rv_ifu #(
    .RESET_PC(RESET_PC)
  ) u_ifu (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_dec          (dec),
    .i_target       (target),
    .i_a0           (a0),
    .o_pc           (o_pc),
    .o_run          (run),
    .o_halt         (o_halt),
    .o_halt_illegal (o_halt_illegal),
    .o_halt_a0      (o_halt_a0)
  );

  rv_idu u_idu (
    .i_inst (i_inst),
    .o_dec  (dec)
  );

  // nothing is written once halted
  rv_regfile u_regfile (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_ra      (dec.ra),
    .i_rb      (dec.rb),
    .i_wen     (dec.wen & run),
    .i_rd      (dec.rd),
    .i_wdata   (result),
    .o_rdata_a (rs1),
    .o_rdata_b (rs2),
    .o_a0      (a0)
  );

  rv_exu u_exu (
    .i_dec    (dec),
    .i_pc     (o_pc),
    .i_rs1    (rs1),
    .i_rs2    (rs2),
    .o_result (result),
    .o_target (target)
  );

  assign o_store_valid = dec.is_store & run;
  assign o_store_addr  = result;
  assign o_store_data  = rs2;

endmodule

/* hdl/rv_exu.sv */
// single-cycle execute; only add and immediate copy exist, other ops give zero
`timescale 1ns/100ps

module rv_exu (
  input  rv_pkg::decode_t i_dec,
  input  rv_pkg::xlen_t   i_pc,
  input  rv_pkg::xlen_t   i_rs1,
  input  rv_pkg::xlen_t   i_rs2,
  output rv_pkg::xlen_t   o_result,
  output rv_pkg::xlen_t   o_target
);

  import rv_pkg::*;

  xlen_t op_a;
  xlen_t op_b;
  xlen_t base;

  assign op_a = (i_dec.opa == OPA_PC) ? i_pc : i_rs1;

  always_comb begin
    case (i_dec.opb)
      OPB_RS2:  op_b = i_rs2;
      OPB_IMM:  op_b = i_dec.imm;
      OPB_FOUR: op_b = 64'd4;
      default:  op_b = '0;
    endcase
  end

  // jal and jalr land here as pc + 4 for the link
  always_comb begin
    case (i_dec.alu_op)
      ALU_ADD:      o_result = op_a + op_b;
      ALU_COPY_IMM: o_result = i_dec.imm;
      default:      o_result = '0;
    endcase
  end

  // jump target, jalr takes rs1 as its base
  assign base     = i_dec.pc_base_reg ? i_rs1 : op_a;
  assign o_target = base + i_dec.imm;

endmodule

/* hdl/rv_idu.sv */
// decodes lui, auipc, jal, jalr, addi, sd and ebreak only; any other encoding comes out as ALU_ILLEGAL
`timescale 1ns/100ps

module rv_idu (
  input  rv_pkg::inst_t   i_inst,
  output rv_pkg::decode_t o_dec
);

  import rv_pkg::*;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];

  // immediates, all sign extended
  xlen_t imm_i;
  xlen_t imm_u;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_j;

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  logic inst_lui;
  logic inst_auipc;
  logic inst_jal;
  logic inst_jalr;
  logic inst_addi;
  logic inst_ebreak;
  logic inst_sd;

  assign inst_lui    = (opcode == OP_LUI);
  assign inst_auipc  = (opcode == OP_AUIPC);
  assign inst_jal    = (opcode == OP_JAL);
  assign inst_jalr   = (opcode == OP_JALR) & (funct3 == 3'b000);
  assign inst_addi   = (opcode == OP_IMM) & (funct3 == 3'b000);
  // only the exact ebreak word, ecall and the rest of system stay illegal
  assign inst_ebreak = (opcode == OP_SYSTEM) & (i_inst[31:7] == 25'h0002000);
  assign inst_sd     = (opcode == OP_STORE) & (funct3 == 3'b011);

  // r and b types reserved, nothing decodes to them yet
  logic type_r;
  logic type_i;
  logic type_u;
  logic type_s;
  logic type_b;
  logic type_j;
  logic [5:0] inst_type;

  assign type_r    = 1'b0;
  assign type_i    = inst_addi | inst_ebreak | inst_jalr;
  assign type_u    = inst_lui | inst_auipc;
  assign type_s    = inst_sd;
  assign type_b    = 1'b0;
  assign type_j    = inst_jal;
  assign inst_type = {type_r, type_i, type_u, type_s, type_b, type_j};

  xlen_t   imm;
  alu_op_e alu_op;
  logic    alu_copy;
  logic    alu_plus;

  always_comb begin
    case (inst_type)
      6'b010000: imm = imm_i;
      6'b001000: imm = imm_u;
      6'b000100: imm = imm_s;
      6'b000010: imm = imm_b;
      6'b000001: imm = imm_j;
      default:   imm = '0;
    endcase
  end

  assign alu_copy = inst_lui;
  assign alu_plus = inst_auipc | inst_jal | inst_jalr | inst_addi | inst_sd;

  always_comb begin
    case ({alu_copy, alu_plus, inst_ebreak})
      3'b100:  alu_op = ALU_COPY_IMM;
      3'b010:  alu_op = ALU_ADD;
      3'b001:  alu_op = ALU_EBREAK;
      default: alu_op = ALU_ILLEGAL;
    endcase
  end

  always_comb begin
    o_dec.ra       = i_inst[19:15];
    o_dec.rb       = i_inst[24:20];
    o_dec.rd       = i_inst[11:7];
    o_dec.imm      = imm;
    o_dec.alu_op   = alu_op;
    // ebreak writes nothing
    o_dec.wen      = (type_r | type_i | type_u | type_j) & ~inst_ebreak;
    o_dec.is_store = inst_sd;
    // link and auipc work from the pc
    o_dec.opa      = (inst_jal | inst_auipc | inst_jalr) ? OPA_PC : OPA_RS1;
    if (inst_jal | inst_jalr) begin
      o_dec.opb = OPB_FOUR;
    end else if (type_i | type_u | type_s | type_b) begin
      o_dec.opb = OPB_IMM;
    end else begin
      o_dec.opb = OPB_RS2;
    end
    o_dec.pc_jump     = inst_jal | inst_jalr;
    o_dec.pc_base_reg = inst_jalr;
  end

endmodule

/* hdl/rv_ifu.sv */
// pc and halt state; the pc stays on the halting instruction and only reset restarts the core
`timescale 1ns/100ps

module rv_ifu #(
  parameter rv_pkg::xlen_t RESET_PC = '0
) (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  rv_pkg::decode_t i_dec,
  input  rv_pkg::xlen_t   i_target,
  input  rv_pkg::xlen_t   i_a0,
  output rv_pkg::xlen_t   o_pc,
  output logic            o_run,
  output logic            o_halt,
  output logic            o_halt_illegal,
  output rv_pkg::xlen_t   o_halt_a0
);

  import rv_pkg::*;

  typedef enum logic {
    RUNNING = 1'b0,
    HALTED  = 1'b1
  } halt_state_e;

  halt_state_e state;
  xlen_t       pc;
  xlen_t       next_pc;
  logic        stop;

  assign stop = (i_dec.alu_op == ALU_EBREAK) || (i_dec.alu_op == ALU_ILLEGAL);

  always_comb begin
    if (!i_dec.pc_jump) begin
      next_pc = pc + 64'd4;
    end else if (i_dec.pc_base_reg) begin
      next_pc = {i_target[63:1], 1'b0};
    end else begin
      next_pc = i_target;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state          <= RUNNING;
      pc             <= RESET_PC;
      o_halt_illegal <= 1'b0;
    end else if (state == RUNNING) begin
      if (stop) begin
        state          <= HALTED;
        o_halt_illegal <= (i_dec.alu_op == ALU_ILLEGAL);
      end else begin
        pc <= next_pc;
      end
    end
  end

  // a0 as it stood before the halting instruction
  always_ff @(posedge i_clk) begin
    if ((state == RUNNING) && stop) begin
      o_halt_a0 <= i_a0;
    end
  end

  assign o_pc   = pc;
  // no writes or stores while reset is held
  assign o_run  = (state == RUNNING) && i_rst_n;
  assign o_halt = (state == HALTED);

endmodule

/* hdl/rv_pkg.sv */
// shared types for the rv64i subset core; xlen is fixed at 64 and only the decoded subset exists
package rv_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // execute operation, encodings kept from the older decoder
  typedef enum logic [3:0] {
    ALU_ADD      = 4'b0000,
    ALU_COPY_IMM = 4'b0011,
    ALU_EBREAK   = 4'b1110,
    ALU_ILLEGAL  = 4'b1111
  } alu_op_e;

  typedef enum logic {
    OPA_RS1 = 1'b0,
    OPA_PC  = 1'b1
  } opa_sel_e;

  typedef enum logic [1:0] {
    OPB_RS2  = 2'b00,
    OPB_IMM  = 2'b01,
    OPB_FOUR = 2'b10
  } opb_sel_e;

  // everything the decoder derives from one instruction
  typedef struct packed {
    reg_idx_t ra;
    reg_idx_t rb;
    reg_idx_t rd;
    xlen_t    imm;
    logic     wen;
    logic     is_store;
    opa_sel_e opa;
    opb_sel_e opb;
    alu_op_e  alu_op;
    logic     pc_jump;
    logic     pc_base_reg;
  } decode_t;

  // a0 is reported on halt
  localparam reg_idx_t EBREAK_A0 = 5'd10;

endpackage

/* hdl/rv_regfile.sv */
// 31 general registers plus a zero x0; reads are combinational and see the value before a same-cycle write
`timescale 1ns/100ps

module rv_regfile (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  rv_pkg::reg_idx_t i_ra,
  input  rv_pkg::reg_idx_t i_rb,
  input  logic             i_wen,
  input  rv_pkg::reg_idx_t i_rd,
  input  rv_pkg::xlen_t    i_wdata,
  output rv_pkg::xlen_t    o_rdata_a,
  output rv_pkg::xlen_t    o_rdata_b,
  output rv_pkg::xlen_t    o_a0
);

  import rv_pkg::*;

  // x0 has no storage
  xlen_t regs [1:31];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rdata_a = (i_ra == '0) ? '0 : regs[i_ra];
  assign o_rdata_b = (i_rb == '0) ? '0 : regs[i_rb];

  assign o_a0 = regs[EBREAK_A0];

endmodule

/* src.f */
hdl/rv_pkg.sv
hdl/rv_idu.sv
hdl/rv_regfile.sv
hdl/rv_exu.sv
hdl/rv_ifu.sv
hdl/rv_core.sv
dv/rv_core_asserts.sv
dv/rv_core_checker.sv
dv/tb_rv_core.sv
